/* src/fsab_mem_pkg.sv */
package fsab_mem_pkg;

	localparam int FSAB_DATA_W          = 64;
	localparam int FSAB_MASK_W          = FSAB_DATA_W / 8;
	localparam int FSAB_ADDR_W          = 31;
	localparam int FSAB_DID_W           = 4;
	localparam int FSAB_LEN_W           = 4;
	localparam int FSAB_LEN_MAX         = 8;	// Lengths run 1 to 8
	localparam int FSAB_INITIAL_CREDITS = 4;

	localparam int MEM_WORDS      = 256;
	localparam int MEM_IDX_W      = 8;
	localparam int RSP_DATA_DEPTH = 2 * FSAB_LEN_MAX;	// Two full bursts

	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_t;

	typedef struct packed {
		fsab_mode_t             mode;
		logic [FSAB_DID_W-1:0]  did;
		logic [FSAB_DID_W-1:0]  subdid;
		logic [FSAB_ADDR_W-1:0] addr;
		logic [FSAB_LEN_W-1:0]  len;
	} fsab_req_t;

	typedef struct packed {
		logic [FSAB_DATA_W-1:0] data;
		logic [FSAB_MASK_W-1:0] mask;
	} fsab_beat_t;

	typedef struct packed {
		logic [FSAB_DID_W-1:0] did;
		logic [FSAB_DID_W-1:0] subdid;
		logic [FSAB_LEN_W-1:0] len;
	} fsab_rsp_t;

endpackage

/* src/fsab_fifo.sv */
`timescale 1ns/10ps

module fsab_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic                         clk0_tb,
	input  logic                         rst0_tb,
	input  logic                         push,
	input  payload_t                     push_data,
	input  logic                         pop,
	output payload_t                     head,
	output logic                         empty,
	output logic                         full,
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	assign head  = mem[rd_ptr];	// Show-ahead, no pop needed
	assign empty = (count == '0);
	assign full  = (count == DEPTH);

	always_ff @(posedge clk0_tb) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk0_tb or negedge rst0_tb) begin
		if (!rst0_tb) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		!(push && full))
		else $error("fsab_fifo: push while full");

	a_no_underflow: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		!(pop && empty))
		else $error("fsab_fifo: pop while empty");

endmodule

/* src/fsab_ingress.sv */
`timescale 1ns/10ps

module fsab_ingress (
	input  logic                                   clk0_tb,
	input  logic                                   rst0_tb,
	input  logic                                   fsabo_valid,
	input  fsab_mem_pkg::fsab_mode_t               fsabo_mode,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0]    fsabo_did,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0]    fsabo_subdid,
	input  logic [fsab_mem_pkg::FSAB_ADDR_W-1:0]   fsabo_addr,
	input  logic [fsab_mem_pkg::FSAB_LEN_W-1:0]    fsabo_len,
	input  logic [fsab_mem_pkg::FSAB_DATA_W-1:0]   fsabo_data,
	input  logic [fsab_mem_pkg::FSAB_MASK_W-1:0]   fsabo_mask,
	input  logic                                   req_pop,
	input  logic                                   beat_pop,
	output logic                                   req_avail,
	output fsab_mem_pkg::fsab_mode_t               req_mode,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0]    req_did,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0]    req_subdid,
	output logic [fsab_mem_pkg::FSAB_ADDR_W-1:0]   req_addr,
	output logic [fsab_mem_pkg::FSAB_LEN_W-1:0]    req_len,
	output logic [fsab_mem_pkg::FSAB_DATA_W-1:0]   beat_data,
	output logic [fsab_mem_pkg::FSAB_MASK_W-1:0]   beat_mask
);
	import fsab_mem_pkg::*;

	logic [FSAB_LEN_W-1:0]                      beats_rem;	// Write beats still to come
	logic                                       hdr_beat;
	logic                                       data_beat;
	logic                                       beat_push;
	logic                                       req_done;
	fsab_req_t                                  req_in;
	fsab_req_t                                  req_head;
	fsab_beat_t                                 beat_in;
	fsab_beat_t                                 beat_head;
	logic [$clog2(FSAB_INITIAL_CREDITS+1)-1:0]  req_count;
	logic [$clog2(FSAB_INITIAL_CREDITS+1)-1:0]  queued;

	assign hdr_beat  = fsabo_valid && (beats_rem == '0);
	assign data_beat = fsabo_valid && (beats_rem != '0);
	assign beat_push = data_beat || (hdr_beat && fsabo_mode == FSAB_WRITE);
	// A read is complete at its header, a write at its last beat
	assign req_done  = (hdr_beat && (fsabo_mode == FSAB_READ || fsabo_len == 1)) ||
	                   (data_beat && beats_rem == 1);

	assign req_in.mode   = fsabo_mode;
	assign req_in.did    = fsabo_did;
	assign req_in.subdid = fsabo_subdid;
	assign req_in.addr   = fsabo_addr;
	assign req_in.len    = fsabo_len;
	assign beat_in.data  = fsabo_data;
	assign beat_in.mask  = fsabo_mask;

	fsab_fifo #(.payload_t(fsab_req_t), .DEPTH(FSAB_INITIAL_CREDITS)) u_req_fifo (
		.clk0_tb(clk0_tb), .rst0_tb(rst0_tb), .push(hdr_beat), .push_data(req_in),
		.pop(req_pop), .head(req_head), .empty(), .full(), .count(req_count));

	fsab_fifo #(.payload_t(fsab_beat_t), .DEPTH(FSAB_INITIAL_CREDITS * FSAB_LEN_MAX)) u_beat_fifo (
		.clk0_tb(clk0_tb), .rst0_tb(rst0_tb), .push(beat_push), .push_data(beat_in),
		.pop(beat_pop), .head(beat_head), .empty(), .full(), .count());

	assign req_avail  = (queued != '0);
	assign req_mode   = req_head.mode;
	assign req_did    = req_head.did;
	assign req_subdid = req_head.subdid;
	assign req_addr   = req_head.addr;
	assign req_len    = req_head.len;
	assign beat_data  = beat_head.data;
	assign beat_mask  = beat_head.mask;

	always_ff @(posedge clk0_tb or negedge rst0_tb) begin
		if (!rst0_tb) begin
			beats_rem <= '0;
			queued    <= '0;
		end else begin
			if (hdr_beat && fsabo_mode == FSAB_WRITE)
				beats_rem <= fsabo_len - 1'b1;
			else if (data_beat)
				beats_rem <= beats_rem - 1'b1;
			case ({req_done, req_pop})
				2'b10:   queued <= queued + 1'b1;
				2'b01:   queued <= queued - 1'b1;
				default: queued <= queued;
			endcase
		end
	end

	// Master sent a header without holding a credit
	a_credit_respected: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		hdr_beat |-> (req_count < FSAB_INITIAL_CREDITS))
		else $error("fsab_ingress: header beyond credit limit");

endmodule

/* src/mem_ctrl.sv */
`timescale 1ns/10ps

module mem_ctrl (
	input  logic                                   clk0_tb,
	input  logic                                   rst0_tb,
	input  logic                                   req_avail,
	input  fsab_mem_pkg::fsab_mode_t               req_mode,
	input  logic [fsab_mem_pkg::FSAB_ADDR_W-1:0]   req_addr,
	input  logic [fsab_mem_pkg::FSAB_LEN_W-1:0]    req_len,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0]    req_did,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0]    req_subdid,
	input  logic [fsab_mem_pkg::FSAB_DATA_W-1:0]   beat_data,
	input  logic [fsab_mem_pkg::FSAB_MASK_W-1:0]   beat_mask,
	input  logic                                   rsp_room,
	output logic                                   req_pop,
	output logic                                   beat_pop,
	output logic                                   wr_en,
	output logic [fsab_mem_pkg::MEM_IDX_W-1:0]     wr_idx,
	output logic [fsab_mem_pkg::FSAB_DATA_W-1:0]   wr_data,
	output logic [fsab_mem_pkg::FSAB_MASK_W-1:0]   wr_mask,
	output logic                                   rd_en,
	output logic [fsab_mem_pkg::MEM_IDX_W-1:0]     rd_idx,
	output logic                                   rsp_push,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0]    rsp_did,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0]    rsp_subdid,
	output logic [fsab_mem_pkg::FSAB_LEN_W-1:0]    rsp_len,
	output logic                                   rd_valid,
	output logic                                   fsabo_credit
);
	import fsab_mem_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ
	} state_t;

	state_t                state;
	logic [FSAB_LEN_W-1:0] beat_cnt;	// Beats left in current request
	logic [MEM_IDX_W-1:0]  idx;
	logic                  start;

	// Reads also need room for a whole burst in the response queues
	assign start = (state == ST_IDLE) && req_avail && (req_mode == FSAB_WRITE || rsp_room);

	assign req_pop    = start;
	assign rsp_push   = start && (req_mode == FSAB_READ);
	assign rsp_did    = req_did;
	assign rsp_subdid = req_subdid;
	assign rsp_len    = req_len;

	assign wr_en    = (state == ST_WRITE);
	assign beat_pop = wr_en;	// One queued beat per memory write
	assign wr_idx   = idx;
	assign wr_data  = beat_data;
	assign wr_mask  = beat_mask;
	assign rd_en    = (state == ST_READ);
	assign rd_idx   = idx;

	always_ff @(posedge clk0_tb or negedge rst0_tb) begin
		if (!rst0_tb) begin
			state        <= ST_IDLE;
			beat_cnt     <= '0;
			idx          <= '0;
			rd_valid     <= 1'b0;
			fsabo_credit <= 1'b0;
		end else begin
			rd_valid     <= rd_en;	// RAM data shows up one cycle later
			fsabo_credit <= (state != ST_IDLE) && (beat_cnt == 1);
			if (start) begin
				state    <= (req_mode == FSAB_WRITE) ? ST_WRITE : ST_READ;
				beat_cnt <= req_len;
				idx      <= req_addr[$clog2(FSAB_MASK_W) +: MEM_IDX_W];
			end else if (state != ST_IDLE) begin
				beat_cnt <= beat_cnt - 1'b1;
				idx      <= idx + 1'b1;	// Wraps at MEM_WORDS
				if (beat_cnt == 1)
					state <= ST_IDLE;
			end
		end
	end

	a_idle_when_done: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		(beat_cnt == '0) |-> (state == ST_IDLE))
		else $error("mem_ctrl: busy with no beats left");

endmodule

/* src/word_ram.sv */
`timescale 1ns/10ps

module word_ram (
	input  logic                                   clk0_tb,
	input  logic                                   wr_en,
	input  logic [fsab_mem_pkg::MEM_IDX_W-1:0]     wr_idx,
	input  logic [fsab_mem_pkg::FSAB_DATA_W-1:0]   wr_data,
	input  logic [fsab_mem_pkg::FSAB_MASK_W-1:0]   wr_mask,
	input  logic                                   rd_en,
	input  logic [fsab_mem_pkg::MEM_IDX_W-1:0]     rd_idx,
	output logic [fsab_mem_pkg::FSAB_DATA_W-1:0]   rd_data
);
	import fsab_mem_pkg::*;

	logic [FSAB_DATA_W-1:0] mem [MEM_WORDS];

	// Byte lanes with a clear mask bit keep their old value
	always_ff @(posedge clk0_tb) begin
		if (wr_en) begin
			for (int b = 0; b < FSAB_MASK_W; b++) begin
				if (wr_mask[b])
					mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (rd_en)
			rd_data <= mem[rd_idx];	// Registered read
	end

endmodule

/* src/fsab_egress.sv */
`timescale 1ns/10ps

module fsab_egress (
	input  logic                                   clk0_tb,
	input  logic                                   rst0_tb,
	input  logic                                   rsp_push,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0]    rsp_did,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0]    rsp_subdid,
	input  logic [fsab_mem_pkg::FSAB_LEN_W-1:0]    rsp_len,
	input  logic                                   rd_valid,
	input  logic [fsab_mem_pkg::FSAB_DATA_W-1:0]   rd_data,
	output logic                                   rsp_room,
	output logic                                   fsabi_valid,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0]    fsabi_did,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0]    fsabi_subdid,
	output logic [fsab_mem_pkg::FSAB_DATA_W-1:0]   fsabi_data
);
	import fsab_mem_pkg::*;

	fsab_rsp_t                             hdr_in;
	fsab_rsp_t                             hdr_head;
	logic                                  hdr_empty;
	logic                                  hdr_full;
	logic [FSAB_DATA_W-1:0]                data_head;
	logic                                  data_empty;
	logic [$clog2(RSP_DATA_DEPTH+1)-1:0]   data_count;
	logic [FSAB_LEN_W-1:0]                 beats_left;	// Beats still to pop in burst
	logic                                  start;
	logic                                  data_pop;

	assign hdr_in.did    = rsp_did;
	assign hdr_in.subdid = rsp_subdid;
	assign hdr_in.len    = rsp_len;

	fsab_fifo #(.payload_t(fsab_rsp_t), .DEPTH(2)) u_hdr_fifo (
		.clk0_tb(clk0_tb), .rst0_tb(rst0_tb), .push(rsp_push), .push_data(hdr_in),
		.pop(start), .head(hdr_head), .empty(hdr_empty), .full(hdr_full), .count());

	fsab_fifo #(.payload_t(logic [FSAB_DATA_W-1:0]), .DEPTH(RSP_DATA_DEPTH)) u_data_fifo (
		.clk0_tb(clk0_tb), .rst0_tb(rst0_tb), .push(rd_valid), .push_data(rd_data),
		.pop(data_pop), .head(data_head), .empty(data_empty), .full(), .count(data_count));

	// Word in flight from the RAM counts as already queued
	assign rsp_room = !hdr_full && ((data_count + rd_valid) <= (RSP_DATA_DEPTH - FSAB_LEN_MAX));

	assign start    = (beats_left == '0) && !hdr_empty && !data_empty;
	assign data_pop = start || (beats_left != '0);

	always_ff @(posedge clk0_tb or negedge rst0_tb) begin
		if (!rst0_tb) begin
			beats_left  <= '0;
			fsabi_valid <= 1'b0;
		end else begin
			fsabi_valid <= data_pop;
			if (start)
				beats_left <= hdr_head.len - 1'b1;
			else if (beats_left != '0)
				beats_left <= beats_left - 1'b1;
		end
	end

	always_ff @(posedge clk0_tb) begin
		fsabi_data <= data_head;
		if (start) begin
			fsabi_did    <= hdr_head.did;	// Held for the whole burst
			fsabi_subdid <= hdr_head.subdid;
		end
	end

	a_data_keeps_up: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		(beats_left != '0) |-> !data_empty)
		else $error("fsab_egress: read data late during burst");

endmodule

/* src/fsab_mem_top.sv */
`timescale 1ns/10ps

module fsab_mem_top (
	input  logic                                   clk0_tb,
	input  logic                                   rst0_tb,
	input  logic                                   fsabo_valid,
	input  fsab_mem_pkg::fsab_mode_t               fsabo_mode,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0]    fsabo_did,
	input  logic [fsab_mem_pkg::FSAB_DID_W-1:0]    fsabo_subdid,
	input  logic [fsab_mem_pkg::FSAB_ADDR_W-1:0]   fsabo_addr,
	input  logic [fsab_mem_pkg::FSAB_LEN_W-1:0]    fsabo_len,
	input  logic [fsab_mem_pkg::FSAB_DATA_W-1:0]   fsabo_data,
	input  logic [fsab_mem_pkg::FSAB_MASK_W-1:0]   fsabo_mask,
	output logic                                   fsabo_credit,
	output logic                                   fsabi_valid,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0]    fsabi_did,
	output logic [fsab_mem_pkg::FSAB_DID_W-1:0]    fsabi_subdid,
	output logic [fsab_mem_pkg::FSAB_DATA_W-1:0]   fsabi_data
);
	import fsab_mem_pkg::*;

	logic                   req_avail;
	logic                   req_pop;
	logic                   beat_pop;
	fsab_mode_t             req_mode;
	logic [FSAB_DID_W-1:0]  req_did;
	logic [FSAB_DID_W-1:0]  req_subdid;
	logic [FSAB_ADDR_W-1:0] req_addr;
	logic [FSAB_LEN_W-1:0]  req_len;
	logic [FSAB_DATA_W-1:0] beat_data;
	logic [FSAB_MASK_W-1:0] beat_mask;
	logic                   wr_en;
	logic [MEM_IDX_W-1:0]   wr_idx;
	logic [FSAB_DATA_W-1:0] wr_data;
	logic [FSAB_MASK_W-1:0] wr_mask;
	logic                   rd_en;
	logic [MEM_IDX_W-1:0]   rd_idx;
	logic [FSAB_DATA_W-1:0] rd_data;
	logic                   rd_valid;
	logic                   rsp_room;
	logic                   rsp_push;
	logic [FSAB_DID_W-1:0]  rsp_did;
	logic [FSAB_DID_W-1:0]  rsp_subdid;
	logic [FSAB_LEN_W-1:0]  rsp_len;

	fsab_ingress u_ingress (
		.clk0_tb, .rst0_tb, .fsabo_valid, .fsabo_mode, .fsabo_did, .fsabo_subdid,
		.fsabo_addr, .fsabo_len, .fsabo_data, .fsabo_mask, .req_pop, .beat_pop,
		.req_avail, .req_mode, .req_did, .req_subdid, .req_addr, .req_len,
		.beat_data, .beat_mask);

	mem_ctrl u_ctrl (
		.clk0_tb, .rst0_tb, .req_avail, .req_mode, .req_addr, .req_len, .req_did,
		.req_subdid, .beat_data, .beat_mask, .rsp_room, .req_pop, .beat_pop,
		.wr_en, .wr_idx, .wr_data, .wr_mask, .rd_en, .rd_idx, .rsp_push, .rsp_did,
		.rsp_subdid, .rsp_len, .rd_valid, .fsabo_credit);

	word_ram u_ram (
		.clk0_tb, .wr_en, .wr_idx, .wr_data, .wr_mask, .rd_en, .rd_idx, .rd_data);

	fsab_egress u_egress (
		.clk0_tb, .rst0_tb, .rsp_push, .rsp_did, .rsp_subdid, .rsp_len, .rd_valid,
		.rd_data, .rsp_room, .fsabi_valid, .fsabi_did, .fsabi_subdid, .fsabi_data);

endmodule

/* testbench/tb_fsab_mem.sv */
`timescale 1ns/10ps

module tb_fsab_mem;
	import fsab_mem_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int EXP_MAX    = 512;	// Expected read beats over all tests
	localparam int WD_PER_REQ = 200;
	localparam int WD_MARGIN  = 500;
	localparam int BYTE_W     = $clog2(FSAB_MASK_W);
	localparam int ADDR_HI_W  = FSAB_ADDR_W - MEM_IDX_W - BYTE_W;

	logic                   clk0_tb;
	logic                   rst0_tb;
	logic                   fsabo_valid;
	fsab_mode_t             fsabo_mode;
	logic [FSAB_DID_W-1:0]  fsabo_did;
	logic [FSAB_DID_W-1:0]  fsabo_subdid;
	logic [FSAB_ADDR_W-1:0] fsabo_addr;
	logic [FSAB_LEN_W-1:0]  fsabo_len;
	logic [FSAB_DATA_W-1:0] fsabo_data;
	logic [FSAB_MASK_W-1:0] fsabo_mask;
	logic                   fsabo_credit;
	logic                   fsabi_valid;
	logic [FSAB_DID_W-1:0]  fsabi_did;
	logic [FSAB_DID_W-1:0]  fsabi_subdid;
	logic [FSAB_DATA_W-1:0] fsabi_data;

	logic                   hdr_cyc;	// Driven beat is a header
	int                     credits;
	int                     credits_back;
	int                     issued;
	int                     errors;
	int                     tests_failed;
	int                     test_num;
	int                     exp_cnt;
	int                     exp_rd;
	logic [FSAB_DATA_W-1:0] ref_mem [MEM_WORDS];
	logic [FSAB_DATA_W-1:0] exp_data [EXP_MAX];
	logic [FSAB_DID_W-1:0]  exp_did [EXP_MAX];
	logic [FSAB_DID_W-1:0]  exp_subdid [EXP_MAX];
	logic                   exp_last [EXP_MAX];
	logic [FSAB_DATA_W-1:0] beat_buf [FSAB_LEN_MAX];
	logic [FSAB_MASK_W-1:0] mask_buf [FSAB_LEN_MAX];

	fsab_mem_top u_dut (.*);

	always #(CLK_PERIOD / 2) clk0_tb = ~clk0_tb;

	// Credit count and position in the expected response stream
	always @(posedge clk0_tb or negedge rst0_tb) begin
		if (!rst0_tb) begin
			credits      <= FSAB_INITIAL_CREDITS;
			credits_back <= 0;
			exp_rd       <= 0;
		end else begin
			if (fsabo_valid && hdr_cyc && !fsabo_credit)
				credits <= credits - 1;
			else if (fsabo_credit && !(fsabo_valid && hdr_cyc))
				credits <= credits + 1;
			if (fsabo_credit)
				credits_back <= credits_back + 1;
			if (fsabi_valid)
				exp_rd <= exp_rd + 1;
		end
	end

	function automatic void log_error(input string msg);
		errors++;
		$display("[ERROR] %0d ns: %s", $time, msg);
	endfunction

	a_quiet_after_reset: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		(issued == 0) |-> (!fsabo_credit && !fsabi_valid))
		else log_error("credit or response before any request");

	a_credit_bounds: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		(credits >= 0) && (credits <= FSAB_INITIAL_CREDITS))
		else log_error("outstanding requests out of range");

	a_credit_owed: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		fsabo_credit |-> (credits < FSAB_INITIAL_CREDITS))
		else log_error("credit returned with no request outstanding");

	a_rsp_expected: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		fsabi_valid |-> (exp_rd < exp_cnt))
		else log_error("read beat with no read pending");

	a_rsp_data: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		(fsabi_valid && exp_rd < exp_cnt) |-> (fsabi_data == exp_data[exp_rd]))
		else log_error("read data differs from reference memory");

	a_rsp_tag: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		(fsabi_valid && exp_rd < exp_cnt) |->
		(fsabi_did == exp_did[exp_rd] && fsabi_subdid == exp_subdid[exp_rd]))
		else log_error("read beat carries wrong did or subdid");

	// Burst has no holes until its last beat
	a_rsp_burst: assert property (@(posedge clk0_tb) disable iff (!rst0_tb)
		(fsabi_valid && exp_rd < exp_cnt && !exp_last[exp_rd]) |=> fsabi_valid)
		else log_error("read burst broken before its last beat");

	function automatic logic [FSAB_DATA_W-1:0] fill_word(input int idx);
		logic [7:0] a;
		a = 8'(idx);
		return {a, ~a, a ^ 8'h5a, a + 8'h11, 8'h3c, a, ~a ^ 8'hc3, 8'hf0 ^ a};
	endfunction

	// Byte b comes from the new word only where mask bit b is set
	function automatic logic [FSAB_DATA_W-1:0] apply_mask(input logic [FSAB_DATA_W-1:0] old_w,
			input logic [FSAB_DATA_W-1:0] new_w, input logic [FSAB_MASK_W-1:0] mask);
		logic [FSAB_DATA_W-1:0] res;
		res = old_w;
		for (int b = 0; b < FSAB_MASK_W; b++) begin
			if (mask[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic drive_idle();
		fsabo_valid <= 1'b0;
		hdr_cyc     <= 1'b0;
	endtask

	task automatic load_random_beats(input bit full_mask);
		for (int i = 0; i < FSAB_LEN_MAX; i++) begin
			beat_buf[i] = {$urandom, $urandom};
			mask_buf[i] = full_mask ? '1 : FSAB_MASK_W'($urandom);
		end
	endtask

	task automatic send_request(input fsab_mode_t mode, input logic [MEM_IDX_W-1:0] idx,
			input int len);
		logic [FSAB_DID_W-1:0] did;
		logic [FSAB_DID_W-1:0] subdid;
		logic [MEM_IDX_W-1:0]  w;
		did    = FSAB_DID_W'($urandom);
		subdid = FSAB_DID_W'($urandom);
		@(posedge clk0_tb);
		// Header driven last edge is not yet in the count
		while (credits - ((fsabo_valid && hdr_cyc) ? 1 : 0) <= 0) begin
			drive_idle();
			@(posedge clk0_tb);
		end
		fsabo_valid  <= 1'b1;
		hdr_cyc      <= 1'b1;
		fsabo_mode   <= mode;
		fsabo_did    <= did;
		fsabo_subdid <= subdid;
		fsabo_addr   <= {ADDR_HI_W'($urandom), idx, {BYTE_W{1'b0}}};	// Upper bits ignored
		fsabo_len    <= FSAB_LEN_W'(len);
		fsabo_data   <= beat_buf[0];
		fsabo_mask   <= mask_buf[0];
		issued++;
		for (int i = 0; i < len; i++) begin
			w = idx + MEM_IDX_W'(i);	// Wraps at MEM_WORDS
			if (mode == FSAB_WRITE) begin
				ref_mem[w] = apply_mask(ref_mem[w], beat_buf[i], mask_buf[i]);
			end else begin
				exp_data[exp_cnt]   = ref_mem[w];
				exp_did[exp_cnt]    = did;
				exp_subdid[exp_cnt] = subdid;
				exp_last[exp_cnt]   = (i == len - 1);
				exp_cnt++;
			end
		end
		if (mode == FSAB_WRITE) begin
			for (int i = 1; i < len; i++) begin
				@(posedge clk0_tb);
				while ($urandom_range(3) == 0) begin	// Random gap between beats
					drive_idle();
					@(posedge clk0_tb);
				end
				fsabo_valid <= 1'b1;
				hdr_cyc     <= 1'b0;
				fsabo_data  <= beat_buf[i];
				fsabo_mask  <= mask_buf[i];
			end
		end
	endtask

	task automatic drain_requests();
		@(posedge clk0_tb);
		drive_idle();
		repeat (2) @(posedge clk0_tb);
		while (credits != FSAB_INITIAL_CREDITS || exp_rd != exp_cnt)
			@(posedge clk0_tb);
		repeat (5) @(posedge clk0_tb);
		a_one_credit_each: assert (credits_back == issued)
			else log_error("credits returned differ from requests issued");
	endtask

	task automatic report_test(input string name, input int err_mark);
		test_num++;
		if (errors == err_mark) begin
			$display("test %0d %s: passed", test_num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", test_num, name, errors - err_mark);
		end
	endtask

	initial begin
		int                   err_mark;
		int                   len;
		logic [MEM_IDX_W-1:0] idx;
		clk0_tb      = 1'b0;
		rst0_tb      = 1'b0;
		fsabo_valid  = 1'b0;
		hdr_cyc      = 1'b0;
		fsabo_mode   = FSAB_READ;
		fsabo_did    = '0;
		fsabo_subdid = '0;
		fsabo_addr   = '0;
		fsabo_len    = '0;
		fsabo_data   = '0;
		fsabo_mask   = '0;
		void'($urandom(32'hebc3));
		repeat (4) @(posedge clk0_tb);
		rst0_tb <= 1'b1;

		err_mark = errors;
		repeat (20) @(posedge clk0_tb);
		report_test("idle after reset", err_mark);

		err_mark = errors;
		for (int w = 0; w < MEM_WORDS / FSAB_LEN_MAX; w++) begin	// Fill whole memory
			for (int i = 0; i < FSAB_LEN_MAX; i++) begin
				beat_buf[i] = fill_word(w * FSAB_LEN_MAX + i);
				mask_buf[i] = '1;
			end
			send_request(FSAB_WRITE, MEM_IDX_W'(w * FSAB_LEN_MAX), FSAB_LEN_MAX);
		end
		send_request(FSAB_READ, MEM_IDX_W'(0), FSAB_LEN_MAX);
		send_request(FSAB_READ, MEM_IDX_W'(96), FSAB_LEN_MAX);
		send_request(FSAB_READ, MEM_IDX_W'(201), 3);
		drain_requests();
		report_test("full-mask write then read", err_mark);

		err_mark = errors;
		for (int n = 0; n < 4; n++) begin
			idx = MEM_IDX_W'($urandom);
			len = $urandom_range(FSAB_LEN_MAX, 1);
			load_random_beats(1'b0);
			send_request(FSAB_WRITE, idx, len);
			send_request(FSAB_READ, idx, len);
		end
		drain_requests();
		report_test("random-mask write", err_mark);

		err_mark = errors;
		for (int n = 0; n < 24; n++) begin
			load_random_beats($urandom_range(1) == 1);
			len = $urandom_range(FSAB_LEN_MAX, 1);
			send_request(fsab_mode_t'($urandom_range(1)), MEM_IDX_W'($urandom), len);
		end
		drain_requests();
		report_test("back-to-back random requests", err_mark);

		err_mark = errors;
		load_random_beats(1'b1);
		send_request(FSAB_WRITE, MEM_IDX_W'(MEM_WORDS - 3), FSAB_LEN_MAX);
		load_random_beats(1'b0);
		send_request(FSAB_WRITE, MEM_IDX_W'(MEM_WORDS - 6), FSAB_LEN_MAX);
		for (int n = 0; n < 4; n++)
			send_request(FSAB_READ, MEM_IDX_W'(MEM_WORDS - 8 + n * 3), FSAB_LEN_MAX);
		drain_requests();
		report_test("read order and index wrap", err_mark);

		$display("tests run %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Budget grows with every request sent
	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= WD_PER_REQ * issued + WD_MARGIN) begin
			@(posedge clk0_tb);
			cycles++;
		end
		$display("Timeout: simulation stopped after %0d cycles without finishing", cycles);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* sources.f */
src/fsab_mem_pkg.sv
src/fsab_fifo.sv
src/fsab_ingress.sv
src/mem_ctrl.sv
src/word_ram.sv
src/fsab_egress.sv
src/fsab_mem_top.sv
testbench/tb_fsab_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module tb_fsab_mem -Mdir "$OBJ"; then
	echo "Verilator build failed"
	exit 1
fi

if ! "./$OBJ/Vtb_fsab_mem" > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi
cat "$LOG"

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
